/* cache_top.f */
logic/cache_pkg.sv
logic/mem_bus_pkg.sv
logic/sram_sp.sv
logic/cpu_req_capture.sv
logic/cache_ctrl.sv
logic/line_xfer_seq.sv
logic/cache_top.sv
verification/cache_checker.sv
verification/cache_sva.sv
verification/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module cache_tb -Mdir "$BUILD_DIR" -f cache_top.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vcache_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  echo "Failure found in $LOG"
  exit 1
fi

echo "Simulation log is in $LOG"
exit 0

/* verification/cache_stimulus.txt */
# kind (0 read, 1 write), word address, write data, byte mask, expected read data; all hex
# expected is address XOR a5a50000 unless an earlier write changed the word
0 00000123 00000000 0 a5a50123
0 00000120 00000000 0 a5a50120
0 0000012f 00000000 0 a5a5012f
1 00000125 11223344 5 00000000
0 00000125 00000000 0 a5220144
0 00000525 00000000 0 a5a50525
0 00000125 00000000 0 a5220144
1 00000200 deadbeef f 00000000
0 00000200 00000000 0 deadbeef
0 00000203 00000000 0 a5a50203
0 00010200 00000000 0 a5a40200
0 00000200 00000000 0 deadbeef
0 3ffffff0 00000000 0 9a5afff0
1 3ffffff1 77000000 8 00000000
0 3ffffff1 00000000 0 775afff1
0 3ffffff5 00000000 0 9a5afff5
0 0000fff1 00000000 0 a5a5fff1
0 3ffffff1 00000000 0 775afff1
1 0000fff2 00abcd00 6 00000000
0 0000fff2 00000000 0 a5abcdf2

/* verification/cache_tb.sv */
module cache_tb
  import cache_pkg::*;
  import mem_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NS_PER_LINE = 2000;

  typedef struct packed {
    logic       is_write;
    word_addr_t addr;
    word_t      data;
    byte_mask_t wmask;
    word_t      expected;
  } stim_t;

  logic      clk;
  logic      reset;
  logic      cpu_req_valid;
  cpu_req_t  cpu_req;
  logic      cpu_req_ready;
  logic      cpu_resp_valid;
  word_t     cpu_resp_data;
  logic      mem_req_valid;
  mem_cmd_t  mem_req;
  logic      mem_req_ready;
  logic      mem_wdata_valid;
  mem_beat_t mem_wdata;
  logic      mem_wdata_ready;
  logic      mem_resp_valid;
  mem_beat_t mem_resp_data;

  logic  exp_push;
  word_t exp_data;
  logic  exp_hit;
  int    chk_errors;
  int    chk_compared;
  int    chk_pending;

  stim_t     stim_q[$];
  mem_addr_t fill_q[$];             // Accepted fill commands
  word_t     mem_words[word_addr_t];  // Only words written back
  tag_t      model_tag[LINES];        // Which line each index holds
  logic      model_valid[LINES];
  int        seed = 66593;
  int        tb_errors = 0;
  bit        loaded = 1'b0;

  cache_clk_gen clk_gen0 (.clk(clk));

  cache_top dut0 (
    .clk            (clk),
    .reset          (reset),
    .cpu_req_valid  (cpu_req_valid),
    .cpu_req        (cpu_req),
    .cpu_req_ready  (cpu_req_ready),
    .cpu_resp_valid (cpu_resp_valid),
    .cpu_resp_data  (cpu_resp_data),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_req_ready  (mem_req_ready),
    .mem_wdata_valid(mem_wdata_valid),
    .mem_wdata      (mem_wdata),
    .mem_wdata_ready(mem_wdata_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data)
  );

  cache_checker chk0 (
    .clk           (clk),
    .reset         (reset),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req       (cpu_req),
    .cpu_req_ready (cpu_req_ready),
    .cpu_resp_valid(cpu_resp_valid),
    .cpu_resp_data (cpu_resp_data),
    .exp_push      (exp_push),
    .exp_data      (exp_data),
    .exp_hit       (exp_hit),
    .error_count   (chk_errors),
    .compared      (chk_compared),
    .pending       (chk_pending)
  );

  // Untouched words read back as address XOR pattern
  function automatic word_t mem_read_word(word_addr_t a);
    if (mem_words.exists(a)) begin
      return mem_words[a];
    end
    return {2'b00, a} ^ 32'hA5A50000;
  endfunction

  function automatic mem_beat_t mem_read_beat(mem_addr_t ba);
    mem_beat_t beat;
    for (int w = 0; w < 4; w++) begin
      beat[w*32 +: 32] = mem_read_word({ba, 2'(w)});
    end
    return beat;
  endfunction

  task automatic load_stimulus();
    int         fd;
    int         n;
    string      line;
    logic [3:0] kind;
    word_addr_t a;
    word_t      d;
    byte_mask_t m;
    word_t      e;
    fd = $fopen("verification/cache_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/cache_stimulus.txt");
      tb_errors++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      n = $sscanf(line, "%h %h %h %h %h", kind, a, d, m, e);
      if (n == 5) begin  // Comment and blank lines match nothing
        stim_q.push_back('{kind[0], a, d, m, e});
      end
    end
    $fclose(fd);
    if (stim_q.size() == 0) begin
      $display("Stimulus file holds no operations");
      tb_errors++;
    end
  endtask

  task automatic send_request(input stim_t s);
    tag_t   tg;
    index_t idx;
    {tg, idx}     = s.addr[29:4];
    cpu_req_valid = 1'b1;
    cpu_req.addr  = s.addr;
    cpu_req.data  = s.data;
    cpu_req.wmask = s.is_write ? s.wmask : '0;
    exp_push      = !s.is_write;
    exp_data      = s.expected;
    exp_hit       = model_valid[idx] && (model_tag[idx] == tg);
    while (!cpu_req_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);  // Accepting edge
    #1;
    cpu_req_valid    = 1'b0;
    exp_push         = 1'b0;
    model_valid[idx] = 1'b1;  // Every access leaves the line resident under write-allocate
    model_tag[idx]   = tg;
  endtask

  // Memory side takes write beats and fill commands
  always @(posedge clk) begin
    if (!reset && mem_req_valid && mem_req_ready) begin
      if (mem_req.rw) begin
        if (mem_wdata_valid && mem_wdata_ready) begin
          for (int w = 0; w < 4; w++) begin
            mem_words[{mem_req.addr, 2'(w)}] = mem_wdata[w*32 +: 32];
          end
        end
      end else begin
        fill_q.push_back(mem_req.addr);
      end
    end
  end

  // Random readies and delayed fill beats
  initial begin
    int        resp_wait;
    int        resp_beat;
    mem_addr_t resp_base;
    mem_req_ready   = 1'b0;
    mem_wdata_ready = 1'b0;
    mem_resp_valid  = 1'b0;
    mem_resp_data   = '0;
    resp_wait       = 0;
    resp_beat       = 4;
    resp_base       = '0;
    forever begin
      @(posedge clk);
      #1;
      mem_req_ready   = ($random(seed) & 3) != 0;  // Ready about three cycles in four
      mem_wdata_ready = ($random(seed) & 3) != 0;
      mem_resp_valid  = 1'b0;
      if (resp_beat < 4) begin
        if (resp_wait > 0) begin
          resp_wait--;
        end else begin
          mem_resp_valid = 1'b1;
          mem_resp_data  = mem_read_beat({resp_base[27:2], 2'(resp_beat)});
          resp_beat++;
        end
      end else if (fill_q.size() > 0) begin
        resp_base = fill_q.pop_front();
        resp_beat = 0;
        resp_wait = $random(seed) & 7;
      end
    end
  end

  initial begin
    cpu_req_valid = 1'b0;
    cpu_req       = '0;
    exp_push      = 1'b0;
    exp_data      = '0;
    exp_hit       = 1'b0;
    reset         = 1'b1;
    for (int i = 0; i < LINES; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    load_stimulus();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (stim_q[i]) begin
      send_request(stim_q[i]);
    end
    // Drain outstanding reads and the last write
    while ((chk_pending != 0) || !cpu_req_ready) begin
      @(posedge clk);
      #1;
    end
    $display("Run done: %0d reads compared, %0d checker errors, %0d testbench errors",
             chk_compared, chk_errors, tb_errors);
    if ((chk_errors == 0) && (tb_errors == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    #((stim_q.size() + 1) * NS_PER_LINE);
    $display("Timeout: run did not finish within %0d ns per operation", NS_PER_LINE);
    $display("TEST FAILED");
    $finish;
  end

endmodule

module cache_clk_gen (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

endmodule

/* verification/cache_sva.sv */
module cache_sva
  import mem_bus_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     cpu_resp_valid,
  input logic     ctrl_idle,
  input logic     xfer_start,
  input logic     xfer_done,
  input logic     mem_req_valid,
  input logic     mem_req_ready,
  input mem_cmd_t mem_req
);

  timeunit 1ns;
  timeprecision 100ps;

  logic xfer_busy;  // From sequencer start up to its done pulse

  always_ff @(posedge clk) begin
    if (reset) begin
      xfer_busy <= 1'b0;
    end else if (xfer_start) begin
      xfer_busy <= 1'b1;
    end else if (xfer_done) begin
      xfer_busy <= 1'b0;
    end
  end

  a_resp_pulse: assert property (@(posedge clk) disable iff (reset)
    cpu_resp_valid |=> !cpu_resp_valid)
    else $error("cpu_resp_valid was high for two cycles in a row");

  // Command must hold while the memory stalls it
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
    else $error("mem_req changed or dropped while mem_req_ready was low");

  a_busy_not_idle: assert property (@(posedge clk) disable iff (reset)
    xfer_busy |-> !ctrl_idle)
    else $error("ctrl_idle was high during a line transfer");

endmodule

bind cache_top cache_sva sva0 (
  .clk           (clk),
  .reset         (reset),
  .cpu_resp_valid(cpu_resp_valid),
  .ctrl_idle     (ctrl_idle),
  .xfer_start    (xfer_start),
  .xfer_done     (xfer_done),
  .mem_req_valid (mem_req_valid),
  .mem_req_ready (mem_req_ready),
  .mem_req       (mem_req)
);

/* verification/cache_checker.sv */
module cache_checker
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     cpu_req_valid,
  input  cpu_req_t cpu_req,
  input  logic     cpu_req_ready,
  input  logic     cpu_resp_valid,
  input  word_t    cpu_resp_data,
  input  logic     exp_push,      // Accepted request is a read
  input  word_t    exp_data,
  input  logic     exp_hit,
  output int       error_count,
  output int       compared,
  output int       pending
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HIT_RISE = 2;  // Edges from acceptance to cpu_resp_valid on a hit

  typedef struct packed {
    word_addr_t addr;
    word_t      data;
    logic       hit;
  } expect_t;

  expect_t exp_q[$];
  int      accept_q[$];   // Edge count of each accepted read
  int      cycle;

  always @(posedge clk) begin
    expect_t exp_cur;
    int      rise;
    if (reset) begin
      cycle       = 0;
      error_count = 0;
      compared    = 0;
      exp_q.delete();
      accept_q.delete();
    end else begin
      cycle++;
      if (cpu_req_valid && cpu_req_ready && exp_push) begin
        exp_q.push_back('{addr: cpu_req.addr, data: exp_data, hit: exp_hit});
        accept_q.push_back(cycle);
      end
      if (cpu_resp_valid) begin
        if (exp_q.size() == 0) begin
          $display("Read response arrived with no read outstanding");
          error_count++;
        end else begin
          exp_cur = exp_q.pop_front();
          rise    = cycle - accept_q.pop_front() - 1;  // Seen one edge after it rose
          compared++;
          if (cpu_resp_data !== exp_cur.data) begin
            $display("error cpu_resp_data: expected %h, got %h (addr %h)",
                     exp_cur.data, cpu_resp_data, exp_cur.addr);
            error_count++;
          end
          if (exp_cur.hit && (rise != HIT_RISE)) begin
            $display("Read hit at address %h answered %0d cycles after acceptance, not %0d",
                     exp_cur.addr, rise, HIT_RISE);
            error_count++;
          end
        end
      end
    end
    pending = exp_q.size();
  end

endmodule

/* logic/cache_top.sv */
module cache_top
  import cache_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // Processor port
  input  logic      cpu_req_valid,
  input  cpu_req_t  cpu_req,
  output logic      cpu_req_ready,
  output logic      cpu_resp_valid,
  output word_t     cpu_resp_data,

  // Memory port
  output logic      mem_req_valid,
  output mem_cmd_t  mem_req,
  input  logic      mem_req_ready,
  output logic      mem_wdata_valid,
  output mem_beat_t mem_wdata,
  input  logic      mem_wdata_ready,
  input  logic      mem_resp_valid,
  input  mem_beat_t mem_resp_data
);

  cpu_req_t               req_hold;
  logic                   req_start;
  logic                   ctrl_idle;
  logic                   xfer_start;
  xfer_kind_t             xfer_kind;
  logic [LINE_ADDR_W-1:0] xfer_line;
  beat_sel_t              beat_sel;
  logic                   fill_we;
  mem_beat_t              fill_data;
  logic                   xfer_done;
  mem_beat_t              wb_data;

  cpu_req_capture u_capture (
    .clk          (clk),
    .reset        (reset),
    .cpu_req_valid(cpu_req_valid),
    .cpu_req      (cpu_req),
    .ctrl_idle    (ctrl_idle),
    .cpu_req_ready(cpu_req_ready),
    .req_hold     (req_hold),
    .req_start    (req_start)
  );

  cache_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .req_hold      (req_hold),
    .req_start     (req_start),
    .ctrl_idle     (ctrl_idle),
    .cpu_resp_valid(cpu_resp_valid),
    .cpu_resp_data (cpu_resp_data),
    .xfer_start    (xfer_start),
    .xfer_kind     (xfer_kind),
    .xfer_line     (xfer_line),
    .beat_sel      (beat_sel),
    .fill_we       (fill_we),
    .fill_data     (fill_data),
    .xfer_done     (xfer_done),
    .wb_data       (wb_data)
  );

  line_xfer_seq u_seq (
    .clk            (clk),
    .reset          (reset),
    .xfer_start     (xfer_start),
    .xfer_kind      (xfer_kind),
    .xfer_line      (xfer_line),
    .wb_data        (wb_data),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_req_ready  (mem_req_ready),
    .mem_wdata_valid(mem_wdata_valid),
    .mem_wdata      (mem_wdata),
    .mem_wdata_ready(mem_wdata_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data),
    .beat_sel       (beat_sel),
    .fill_we        (fill_we),
    .fill_data      (fill_data),
    .xfer_done      (xfer_done)
  );

endmodule

/* logic/line_xfer_seq.sv */
module line_xfer_seq
  import cache_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   xfer_start,
  input  xfer_kind_t             xfer_kind,
  input  logic [LINE_ADDR_W-1:0] xfer_line,
  input  mem_beat_t              wb_data,
  output logic                   mem_req_valid,
  output mem_cmd_t               mem_req,
  input  logic                   mem_req_ready,
  output logic                   mem_wdata_valid,
  output mem_beat_t              mem_wdata,
  input  logic                   mem_wdata_ready,
  input  logic                   mem_resp_valid,
  input  mem_beat_t              mem_resp_data,
  output beat_sel_t              beat_sel,
  output logic                   fill_we,
  output mem_beat_t              fill_data,
  output logic                   xfer_done
);

  xfer_kind_t mode;
  logic       phase;  // Set while a writeback beat is presented or once the fill command is taken
  beat_sel_t  beat;
  logic [LINE_ADDR_W-1:0] line;

  logic wb_fire;
  logic last_beat;

  assign wb_fire   = (mode == XFER_WB) && phase && mem_req_ready && mem_wdata_ready;
  assign last_beat = (beat == 2'd3);

  assign mem_req_valid   = ((mode == XFER_WB) && phase) || ((mode == XFER_FILL) && !phase);
  assign mem_wdata_valid = (mode == XFER_WB) && phase;
  assign mem_wdata       = wb_data;  // Bank row is held while stalled

  always_comb begin
    mem_req.addr = {line, beat};  // Beat stays zero for the fill command
    mem_req.rw   = (mode == XFER_WB);
  end

  assign beat_sel  = beat;
  assign fill_we   = (mode == XFER_FILL) && phase && mem_resp_valid;
  assign fill_data = mem_resp_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      mode      <= XFER_IDLE;
      phase     <= 1'b0;
      beat      <= '0;
      xfer_done <= 1'b0;
    end else begin
      xfer_done <= 1'b0;
      case (mode)
        XFER_IDLE: begin
          if (xfer_start) begin
            mode  <= xfer_kind;
            phase <= 1'b0;
            beat  <= '0;
          end
        end
        XFER_WB: begin
          if (!phase) begin
            phase <= 1'b1;  // Bank row read lands this cycle
          end else if (wb_fire) begin
            phase <= 1'b0;
            beat  <= beat + 2'd1;
            if (last_beat) begin
              mode      <= XFER_IDLE;
              xfer_done <= 1'b1;
            end
          end
        end
        XFER_FILL: begin
          if (!phase) begin
            if (mem_req_ready) begin
              phase <= 1'b1;
            end
          end else if (mem_resp_valid) begin
            beat <= beat + 2'd1;
            if (last_beat) begin
              mode      <= XFER_IDLE;
              phase     <= 1'b0;
              xfer_done <= 1'b1;
            end
          end
        end
        default: mode <= XFER_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (xfer_start && (mode == XFER_IDLE)) begin
      line <= xfer_line;
    end
  end

endmodule

/* logic/cache_ctrl.sv */
module cache_ctrl
  import cache_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  cpu_req_t               req_hold,
  input  logic                   req_start,
  output logic                   ctrl_idle,
  output logic                   cpu_resp_valid,
  output word_t                  cpu_resp_data,
  output logic                   xfer_start,
  output xfer_kind_t             xfer_kind,
  output logic [LINE_ADDR_W-1:0] xfer_line,
  input  beat_sel_t              beat_sel,
  input  logic                   fill_we,
  input  mem_beat_t              fill_data,
  input  logic                   xfer_done,
  output mem_beat_t              wb_data
);

  ctrl_state_t state;
  logic [LINES-1:0] line_valid;   // Cleared by reset, set at end of fill

  tag_t      req_tag;
  index_t    req_index;
  beat_sel_t req_beat;
  word_sel_t req_word;
  logic      req_is_write;

  meta_t meta_rd;
  meta_t meta_wr;
  logic  meta_we;

  logic hit;
  logic victim_dirty;
  logic fill_last;
  logic use_xfer_row;

  logic [BANK_AW-1:0] bank_addr;
  byte_mask_t         bank_mask;
  word_t              bank_dout [NUM_BANKS];

  assign {req_tag, req_index, req_beat, req_word} = req_hold.addr;
  assign req_is_write = |req_hold.wmask;

  // Compared against the registered SRAM outputs in LOOKUP
  assign hit          = line_valid[req_index] && meta_rd.valid && (meta_rd.tag == req_tag);
  assign victim_dirty = line_valid[req_index] && meta_rd.dirty;
  assign fill_last    = fill_we && (beat_sel == 2'd3);

  assign ctrl_idle = (state == IDLE) && !req_start;

  assign xfer_start = (state == WB_WAIT) || (state == FILL_WAIT);

  always_comb begin
    case (state)
      WB_WAIT:   xfer_kind = XFER_WB;
      FILL_WAIT: xfer_kind = XFER_FILL;
      default:   xfer_kind = XFER_IDLE;
    endcase
  end

  // Writeback goes to the victim's tag, fill to the request's
  assign xfer_line = (state == WB_WAIT) ? {meta_rd.tag, req_index} : {req_tag, req_index};

  always_comb begin
    meta_wr       = '0;
    meta_wr.tag   = req_tag;
    meta_wr.valid = 1'b1;
    meta_wr.dirty = (state == WRITE);  // Fill leaves the line clean
  end

  assign meta_we = (state == WRITE) || fill_last;

  sram_sp #(
    .DEPTH(LINES),
    .WIDTH($bits(meta_t))
  ) meta_array (
    .clk  (clk),
    .we   (meta_we),
    .wmask('1),
    .addr (req_index),
    .din  (meta_wr),
    .dout (meta_rd)
  );

  // Sequencer owns the row while beats move; request row again once done
  assign use_xfer_row = ((state == WB_BEAT) || (state == FILL_BEAT)) && !xfer_done;
  assign bank_addr    = {req_index, use_xfer_row ? beat_sel : req_beat};
  assign bank_mask    = fill_we ? '1 : req_hold.wmask;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    sram_sp #(
      .DEPTH(BANK_ROWS),
      .WIDTH(WORD_W)
    ) bank (
      .clk  (clk),
      .we   (fill_we || ((state == WRITE) && (req_word == word_sel_t'(i)))),
      .wmask(bank_mask),
      .addr (bank_addr),
      .din  (fill_we ? fill_data[i*WORD_W +: WORD_W] : req_hold.data),
      .dout (bank_dout[i])
    );

    assign wb_data[i*WORD_W +: WORD_W] = bank_dout[i];  // Word 0 in low bits
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= IDLE;
      line_valid     <= '0;
      cpu_resp_valid <= 1'b0;
    end else begin
      cpu_resp_valid <= 1'b0;
      if (fill_last) begin
        line_valid[req_index] <= 1'b1;
      end
      case (state)
        IDLE: begin
          if (req_start) begin
            state <= LOOKUP;  // SRAMs read the held address this cycle
          end
        end
        LOOKUP: begin
          if (hit) begin
            if (req_is_write) begin
              state <= WRITE;
            end else begin
              cpu_resp_valid <= 1'b1;
              state          <= IDLE;
            end
          end else if (victim_dirty) begin
            state <= WB_WAIT;
          end else begin
            state <= FILL_WAIT;
          end
        end
        WRITE: state <= IDLE;
        WB_WAIT: state <= WB_BEAT;
        WB_BEAT: begin
          if (xfer_done) begin
            state <= FILL_WAIT;
          end
        end
        FILL_WAIT: state <= FILL_BEAT;
        FILL_BEAT: begin
          // Done cycle rereads the new line, then replay
          if (xfer_done) begin
            state <= LOOKUP;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == LOOKUP) begin
      cpu_resp_data <= bank_dout[req_word];
    end
  end

endmodule

/* logic/cpu_req_capture.sv */
module cpu_req_capture
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     cpu_req_valid,
  input  cpu_req_t cpu_req,
  input  logic     ctrl_idle,
  output logic     cpu_req_ready,
  output cpu_req_t req_hold,
  output logic     req_start
);

  logic accept;

  assign cpu_req_ready = ctrl_idle;
  assign accept        = cpu_req_valid && ctrl_idle;

  // Kick the controller one cycle after acceptance
  always_ff @(posedge clk) begin
    if (reset) begin
      req_start <= 1'b0;
    end else begin
      req_start <= accept;
    end
  end

  // Held copy stays put through writeback and refill
  always_ff @(posedge clk) begin
    if (accept) begin
      req_hold <= cpu_req;
    end
  end

endmodule

/* logic/sram_sp.sv */
module sram_sp #(
  parameter int DEPTH = 256,
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [WIDTH/8-1:0]       wmask,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic [WIDTH-1:0]         din,
  output logic [WIDTH-1:0]         dout
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < WIDTH/8; b++) begin
        if (wmask[b]) begin
          mem[addr][b*8 +: 8] <= din[b*8 +: 8];
        end
      end
    end
    // Read returns the old contents on a same-cycle write
    dout <= mem[addr];
  end

endmodule

/* logic/mem_bus_pkg.sv */
package mem_bus_pkg;

  localparam int BEAT_W      = 128;  // Four processor words
  localparam int MEM_ADDR_W  = 28;   // Tag, index, beat number
  localparam int LINE_ADDR_W = 26;   // Tag and index only

  typedef logic [BEAT_W-1:0]     mem_beat_t;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

  typedef struct packed {
    mem_addr_t addr;
    logic      rw;    // 1 for write
  } mem_cmd_t;

  // What the line sequencer is busy with
  typedef enum logic [1:0] {
    XFER_IDLE,
    XFER_WB,
    XFER_FILL
  } xfer_kind_t;

endpackage

/* logic/cache_pkg.sv */
package cache_pkg;

  // Processor side widths
  localparam int WORD_W      = 32;
  localparam int WORD_ADDR_W = 30;
  localparam int TAG_W       = 20;
  localparam int INDEX_W     = 6;

  // Cache geometry
  localparam int LINES     = 64;   // One per index
  localparam int NUM_BANKS = 4;    // Words per memory beat
  localparam int BANK_ROWS = 256;  // Lines times four beats
  localparam int BANK_AW   = 8;    // Index plus beat number

  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [WORD_W/8-1:0]    byte_mask_t;  // All zero means read
  typedef logic [TAG_W-1:0]       tag_t;
  typedef logic [INDEX_W-1:0]     index_t;
  typedef logic [1:0]             beat_sel_t;
  typedef logic [1:0]             word_sel_t;

  // One metadata word per line
  typedef struct packed {
    tag_t                        tag;
    logic                        valid;
    logic                        dirty;
    logic [WORD_W-TAG_W-3:0]     pad;
  } meta_t;

  typedef struct packed {
    word_addr_t addr;
    word_t      data;
    byte_mask_t wmask;
  } cpu_req_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITE,
    WB_WAIT,
    WB_BEAT,
    FILL_WAIT,
    FILL_BEAT
  } ctrl_state_t;

endpackage
